/* whack_a_mole.f */
whack_pkg.sv
press_detect.sv
mole_rng.sv
game_timer.sv
game_fsm.sv
whack_a_mole.sv
tb_whack_a_mole.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_whack_a_mole
FILELIST  ?= whack_a_mole.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell cat $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

/* tb_whack_a_mole.sv */
module tb_whack_a_mole import whack_pkg::*; ();

    localparam int tick_cycles = 2;       // Short tick for simulation
    localparam int num_games   = 3;
    localparam int wait_slack  = 20;      // Extra cycles before a wait gives up

    logic         clk;
    logic         reset;
    lane_t        button;
    lane_t        mole;
    game_status_t status;
    int           cycle;                  // Rising edges since time 0

    // Reference model of the game
    game_state_t  m_state;
    int           m_score;
    int           m_lives;
    int           n_hit;
    int           n_wrong;
    int           n_none;

    whack_a_mole #(
        .cycles_per_tick (tick_cycles)
    ) u_whack_a_mole (
        .clk    (clk),
        .reset  (reset),
        .button (button),
        .mole   (mole),
        .status (status)
    );

    always #10 clk = ~clk;                // Period 20

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    //////////////////////////////////////////////////////////////////////
    // Checking helpers
    //////////////////////////////////////////////////////////////////////
    task automatic fail_and_stop();
        $display("Test failed");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
            fail_and_stop();
        end
    endtask

    // Expected value for a range check is the nearest legal value
    function automatic int nearest_in_range(input int v, input int lo, input int hi);
        if (v < lo) begin
            return lo;
        end
        if (v > hi) begin
            return hi;
        end
        return v;
    endfunction

    // Hammer window in ticks for a given score
    function automatic int window_len(input int score);
        int steps;
        steps = score / int'(speedup_score);
        if (steps > int'(max_speedups)) begin
            steps = int'(max_speedups);              // Speed-up saturates
        end
        return int'(hammer_ticks) - int'(speedup_ticks) * steps;
    endfunction

    function automatic lane_t random_lanes();
        return lane_t'($urandom % 15 + 1);           // Any nonzero button mix
    endfunction

    task automatic check_status();
        check_value("status.state", int'(status.state), int'(m_state));
        check_value("status.score", int'(status.score), m_score);
        check_value("status.lives", int'(status.lives), m_lives);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus tasks are called right after a falling edge
    //////////////////////////////////////////////////////////////////////

    // Hold 3 cycles and release 3 cycles while noting when the DUT reacts
    task automatic press_lanes(input lane_t lanes, output int at_cycle);
        game_status_t before_status;
        lane_t        before_mole;
        int           latency;
        before_status = status;
        before_mole   = mole;
        latency       = 0;
        at_cycle      = 0;
        @(posedge clk);
        button <= lanes;
        for (int i = 1; i <= 6; i++) begin
            @(posedge clk);
            if (i == 3) begin
                button <= '0;                         // Release after 3 cycles
            end
            @(negedge clk);
            if (latency == 0 && (status != before_status || mole != before_mole)) begin
                latency  = i;
                at_cycle = cycle;
            end
        end
        if (latency == 0) begin
            $display("No response from the DUT within 6 cycles of a button press");
            fail_and_stop();
        end
        check_value("press_latency", latency, 4);    // Two sync flops, edge detect, FSM
    endtask

    // Spawn delay runs from the round start to the lit mole
    task automatic wait_for_mole(input int start_cycle, output int mole_cycle);
        int waited;
        int delay;
        int lo;
        int hi;
        lo     = (int'(delay_min_ticks) - 1) * tick_cycles;
        hi     = (int'(delay_min_ticks) + delay_span_ticks) * tick_cycles + 1;
        waited = 0;
        while (mole == '0) begin
            if (waited > hi + wait_slack) begin
                $display("Timed out waiting for a mole to light");
                fail_and_stop();
            end
            check_value("status.state", int'(status.state), int'(st_wait));
            @(negedge clk);
            waited++;
        end
        mole_cycle = cycle;
        delay      = mole_cycle - start_cycle;
        check_value("spawn_delay_cycles", delay, nearest_in_range(delay, lo, hi));
        check_value("mole_onehot", int'($onehot(mole)), 1);
        m_state = st_mole_up;
        check_status();
    endtask

    // Window closes with no press and costs one life
    task automatic let_window_close(input int mole_cycle, input int win, output int at_cycle);
        int waited;
        int len;
        int lo;
        int hi;
        lo     = (win - 1) * tick_cycles;
        hi     = (win + 1) * tick_cycles + 1;
        waited = 0;
        while (int'(status.lives) == m_lives) begin
            if (waited > hi + wait_slack) begin
                $display("Timed out waiting for the hammer window to close");
                fail_and_stop();
            end
            @(negedge clk);
            waited++;
        end
        at_cycle = cycle;
        len      = at_cycle - mole_cycle;
        check_value("window_cycles", len, nearest_in_range(len, lo, hi));
    endtask

    task automatic lose_life();
        m_lives--;
        m_state = (m_lives == 0) ? st_end : st_wait;
    endtask

    //////////////////////////////////////////////////////////////////////
    // One full game from idle to the end screen and back
    //////////////////////////////////////////////////////////////////////
    task automatic play_game();
        int start_cycle;
        int mole_cycle;
        int lit_idx;
        int wrong_idx;
        int choice;
        int win;
        int d;
        press_lanes(random_lanes(), start_cycle);    // Start press
        m_state = st_wait;
        m_score = 0;
        m_lives = int'(start_lives);
        check_status();
        while (m_lives > 0) begin
            wait_for_mole(start_cycle, mole_cycle);
            lit_idx = 0;
            for (int j = 0; j < num_moles; j++) begin
                if (mole[j]) begin
                    lit_idx = j;
                end
            end
            win    = window_len(m_score);            // Score at the moment the mole lit
            choice = int'($urandom % 16);
            if (m_score >= 95) begin
                choice = 1;                           // Keep the score inside 7 bits
            end
            case (choice)
                0: begin                              // Wrong button
                    wrong_idx = (lit_idx + 1 + int'($urandom % 3)) % num_moles;
                    press_lanes(lane_t'(1) << wrong_idx, start_cycle);
                    lose_life();
                    n_wrong++;
                end
                1: begin                              // No press at all
                    let_window_close(mole_cycle, win, start_cycle);
                    lose_life();
                    n_none++;
                end
                default: begin                        // Hit somewhere in the window
                    d = int'($urandom % (win * tick_cycles - 20));
                    repeat (d) @(negedge clk);
                    press_lanes(lane_t'(1) << lit_idx, start_cycle);
                    m_score++;
                    m_state = st_wait;
                    n_hit++;
                end
            endcase
            check_status();
            check_value("mole", int'(mole), 0);
        end
        // End screen holds the score and runs no timer
        for (int j = 0; j < 10; j++) begin
            @(negedge clk);
            check_status();
            check_value("mole", int'(mole), 0);
        end
        press_lanes(random_lanes(), start_cycle);
        m_state = st_idle;
        m_score = 0;
        check_status();
    endtask

    initial begin
        clk     = 1'b0;
        reset   = 1'b1;
        button  = '0;
        cycle   = 0;
        n_hit   = 0;
        n_wrong = 0;
        n_none  = 0;
        void'($urandom(32'hb2e9));
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        m_state = st_idle;                            // Reset state
        m_score = 0;
        m_lives = 0;
        check_status();
        check_value("mole", int'(mole), 0);
        for (int g = 0; g < num_games; g++) begin
            play_game();
        end
        $display("Rounds played: %0d hits, %0d wrong presses, %0d timeouts",
                 n_hit, n_wrong, n_none);
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* whack_a_mole.sv */
module whack_a_mole import whack_pkg::*; #(
    parameter int cycles_per_tick = 500_000     // Clock cycles per 10 ms tick
) (
    input  logic         clk,
    input  logic         reset,
    input  lane_t        button,        // Raw hole buttons
    output lane_t        mole,          // Mole LEDs
    output game_status_t status         // State, score and lives
);

    lane_t              press;
    logic [tick_w-1:0]  rand_delay;
    logic [1:0]         rand_lane;
    logic               load_delay;
    logic               load_window;
    logic               expire;

    // Button synchronizers and edge detect
    press_detect u_press_detect (
        .clk    (clk),
        .reset  (reset),
        .button (button),
        .press  (press)
    );

    // Random spawn delay and lane
    mole_rng u_mole_rng (
        .clk        (clk),
        .reset      (reset),
        .rand_delay (rand_delay),
        .rand_lane  (rand_lane)
    );

    // Tick countdown for delay and window
    game_timer #(
        .cycles_per_tick (cycles_per_tick)
    ) u_game_timer (
        .clk         (clk),
        .reset       (reset),
        .load_delay  (load_delay),
        .load_window (load_window),
        .rand_delay  (rand_delay),
        .score       (status.score),     // Window length follows the score
        .expire      (expire)
    );

    game_fsm u_game_fsm (
        .clk         (clk),
        .reset       (reset),
        .press       (press),
        .expire      (expire),
        .rand_lane   (rand_lane),
        .load_delay  (load_delay),
        .load_window (load_window),
        .mole        (mole),
        .status      (status)
    );

endmodule

/* game_fsm.sv */
module game_fsm import whack_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  lane_t        press,         // One-cycle press pulses
    input  logic         expire,        // Countdown done
    input  logic [1:0]   rand_lane,
    output logic         load_delay,    // Strobe, start spawn delay
    output logic         load_window,   // Strobe, start hammer window
    output lane_t        mole,          // Mole LEDs
    output game_status_t status
);

    logic any_press;
    logic hit;          // Lit lane pressed, nothing else
    logic miss;         // Wrong lane or window closed
    logic last_life;

    //////////////////////////////////////////////////////////////////////
    // Press decode and countdown strobes
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        any_press = |press;
        hit       = ((press & mole) != '0) && ((press & ~mole) == '0);
        miss      = !hit && (any_press || expire);   // A press beats a same-cycle expire
        last_life = (status.lives == lives_w'(1));

        load_delay  = 1'b0;
        load_window = 1'b0;
        case (status.state)
            st_idle: begin
                load_delay = any_press;              // Game start
            end
            st_wait: begin
                load_window = expire;                // Mole lights now
            end
            st_mole_up: begin
                // Next spawn unless the game is over
                load_delay = hit || (miss && !last_life);
            end
            default: begin
                load_delay  = 1'b0;                  // End screen runs no timer
                load_window = 1'b0;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // State, score, lives and mole LEDs
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            status <= '{state: st_idle, score: '0, lives: '0};
            mole   <= '0;
        end else begin
            case (status.state)
                st_idle: begin
                    if (any_press) begin
                        status.score <= '0;
                        status.lives <= start_lives;
                        status.state <= st_wait;
                    end
                end

                st_wait: begin
                    // Presses here are ignored
                    if (expire) begin
                        mole         <= lane_t'(1'b1) << rand_lane;
                        status.state <= st_mole_up;
                    end
                end

                st_mole_up: begin
                    if (hit || miss) begin
                        mole <= '0;                  // Mole hides either way
                        if (hit) begin
                            status.score <= status.score + 1'b1;
                            status.state <= st_wait;
                        end else begin
                            status.lives <= status.lives - 1'b1;
                            status.state <= last_life ? st_end : st_wait;
                        end
                    end
                end

                default: begin                       // st_end, score stays on show
                    if (any_press) begin
                        status.score <= '0;
                        status.state <= st_idle;
                    end
                end
            endcase
        end
    end

    // At most one mole, and only while the window is open
    mole_legal: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(mole) && ((mole == '0) || (status.state == st_mole_up))
    );

endmodule

/* game_timer.sv */
module game_timer import whack_pkg::*; #(
    parameter int cycles_per_tick = 500_000     // 10 ms at 50 MHz
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               load_delay,      // Start spawn delay
    input  logic               load_window,     // Start hammer window
    input  logic [tick_w-1:0]  rand_delay,
    input  logic [score_w-1:0] score,
    output logic               expire           // One-cycle end of countdown
);

    logic [$clog2(cycles_per_tick+1)-1:0] pre_cnt;
    logic                                 tick;
    logic [tick_w-1:0]                    count;          // Ticks left
    logic                                 running;
    logic [score_w-1:0]                   speed_steps;
    logic [tick_w-1:0]                    window_ticks;

    //////////////////////////////////////////////////////////////////////
    // Free-running tick prescaler
    //////////////////////////////////////////////////////////////////////
    assign tick = (pre_cnt == $bits(pre_cnt)'(cycles_per_tick - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pre_cnt <= '0;
        end else if (tick) begin
            pre_cnt <= '0;
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

    // Window shrinks one step per ten points, at most nine steps
    always_comb begin
        speed_steps = score / speedup_score;
        if (speed_steps > max_speedups) begin
            speed_steps = max_speedups;
        end
        window_ticks = hammer_ticks - speedup_ticks * tick_w'(speed_steps);
    end

    //////////////////////////////////////////////////////////////////////
    // Shared countdown
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count   <= '0;
            running <= 1'b0;
            expire  <= 1'b0;
        end else begin
            expire <= 1'b0;
            if (load_delay) begin                    // New load wins over a pending end
                count   <= rand_delay;
                running <= 1'b1;
            end else if (load_window) begin
                count   <= window_ticks;
                running <= 1'b1;
            end else if (running && tick) begin
                count <= count - 1'b1;
                if (count == tick_w'(1)) begin       // Last tick, fire once and stop
                    running <= 1'b0;
                    expire  <= 1'b1;
                end
            end
        end
    end

    load_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(load_delay && load_window)
    );

endmodule

/* mole_rng.sv */
module mole_rng import whack_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    output logic [tick_w-1:0] rand_delay,   // Spawn delay in ticks
    output logic [1:0]        rand_lane     // Index of the next mole
);

    logic [15:0]                         lfsr;
    logic [$clog2(delay_span_ticks)-1:0] delay_off;   // Random part of the delay

    //////////////////////////////////////////////////////////////////////
    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr <= lfsr_seed;
        end else begin
            // Shift right, fold the output bit into the tap positions
            lfsr <= {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hb400 : 16'h0000);
        end
    end

    // Low bits give the delay offset
    assign delay_off  = lfsr[$clog2(delay_span_ticks)-1:0];
    assign rand_delay = delay_min_ticks + tick_w'(delay_off);   // 100 to 227 ticks

    // Lane taken from bits above the delay field
    assign rand_lane  = lfsr[9:8];

    // Zero state would lock the generator for good
    lfsr_nonzero: assert property (
        @(posedge clk) disable iff (reset)
        lfsr != '0
    );

endmodule

/* press_detect.sv */
module press_detect import whack_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  lane_t button,       // Raw asynchronous button levels
    output lane_t press         // One-cycle pulse per rising level
);

    lane_t sync_1;              // First synchronizer stage
    lane_t sync_2;              // Second stage used by the edge detect
    lane_t level_prev;          // Last synchronized level

    // Two-flop synchronizer plus registered edge detect
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync_1     <= '0;
            sync_2     <= '0;
            level_prev <= '0;
            press      <= '0;
        end else begin
            sync_1     <= button;
            sync_2     <= sync_1;
            level_prev <= sync_2;
            press      <= sync_2 & ~level_prev;   // Rising edge only
        end
    end

    // A held button must not repeat the pulse
    press_single: assert property (
        @(posedge clk) disable iff (reset)
        (press & $past(press)) == '0
    );

endmodule

/* whack_pkg.sv */
package whack_pkg;

    //////////////////////////////////////////////////////////////////////
    // Board and counter widths
    //////////////////////////////////////////////////////////////////////
    localparam int num_moles = 4;                 // Holes on the board
    localparam int score_w   = 7;                 // Wide enough to reach 99
    localparam int lives_w   = 2;
    localparam int tick_w    = 10;                // Tick counts, 10 ms each

    localparam logic [lives_w-1:0] start_lives = 2'd3;

    //////////////////////////////////////////////////////////////////////
    // Timing in ticks
    //////////////////////////////////////////////////////////////////////
    localparam logic [tick_w-1:0] delay_min_ticks  = 10'd100;  // Shortest spawn delay
    localparam int                delay_span_ticks = 128;      // Must stay a power of two
    localparam logic [tick_w-1:0] hammer_ticks     = 10'd300;  // Window at score 0
    localparam logic [tick_w-1:0] speedup_ticks    = 10'd25;   // Cut per speed step

    // Speed-up rule, one step per ten points, capped
    localparam logic [score_w-1:0] speedup_score = 7'd10;
    localparam logic [score_w-1:0] max_speedups  = 7'd9;

    localparam logic [15:0] lfsr_seed = 16'hace1;  // Any nonzero start value

    // Game phases
    typedef enum logic [1:0] {
        st_idle    = 2'd0,      // Waiting for a start press
        st_wait    = 2'd1,      // Spawn delay running
        st_mole_up = 2'd2,      // Mole lit, hammer window open
        st_end     = 2'd3       // Final score on show
    } game_state_t;

    // One bit per hole, used for buttons, presses and mole LEDs
    typedef logic [num_moles-1:0] lane_t;

    // Status word shown to the outside
    typedef struct packed {
        game_state_t        state;
        logic [score_w-1:0] score;
        logic [lives_w-1:0] lives;
    } game_status_t;

endpackage
